/* balance_checker.sv */
// balance controller scoreboard mirroring the PID state and checking every output each cycle
module balance_checker #(
  parameter bit fast_sim = 1'b0   // must match the DUT so the I term scales alike
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  vld,
  input  logic signed [balance_pkg::PTCH_W-1:0] ptch,
  input  logic signed [balance_pkg::LD_W-1:0]   ld_cell_diff,
  input  logic                                  rider_off,
  input  logic                                  en_steer,
  input  logic                                  pwr_up,
  input  logic [balance_pkg::SPD_W-1:0]         lft_spd,
  input  logic                                  lft_rev,
  input  logic [balance_pkg::SPD_W-1:0]         rght_spd,
  input  logic                                  rght_rev,
  input  logic                                  ovr_spd,
  output int                                    err_cnt,    // failed compares so far
  output int                                    chk_cnt     // compares done so far
);

  localparam int I_SHIFT   = fast_sim ? 2 : 6;
  localparam int INTEG_MAX = (1 << (balance_pkg::INTEG_W - 1)) - 1;   // 18-bit signed rails
  localparam int INTEG_MIN = -(1 << (balance_pkg::INTEG_W - 1));

  int m_integ;     // mirrored accumulator
  int m_hist1;     // mirrored error one reading back
  int m_hist2;     // mirrored error two readings back
  int upd_err;
  int upd_sum;
  int cur_err;
  int pid;
  int steer;
  int l_spd;
  int r_spd;
  bit l_rev;
  bit r_rev;
  int n_err = 0;
  int n_chk = 0;

  assign err_cnt = n_err;
  assign chk_cnt = n_chk;

  //////////////////////////////////////////////////
  // reference arithmetic
  //////////////////////////////////////////////////

  function automatic int clamp(input int v, input int lo, input int hi);
    return (v > hi) ? hi : ((v < lo) ? lo : v);
  endfunction

  // keep the low torque-width bits, reread as signed
  function automatic int wrap_torque(input int v);
    logic signed [balance_pkg::TORQ_W-1:0] t;
    t = v[balance_pkg::TORQ_W-1:0];
    return int'(t);
  endfunction

  function automatic int pitch_to_err(input logic signed [balance_pkg::PTCH_W-1:0] p);
    return clamp(int'(p), int'(balance_pkg::ERR_MIN), int'(balance_pkg::ERR_MAX));
  endfunction

  // one wheel: low band gets gain, else push MIN_DUTY away from zero
  task automatic shape_wheel(input int t, input bit pwr, output int spd, output bit rev);
    int s;
    int smag;
    if ((t < 0 ? -t : t) < int'(balance_pkg::LOW_TORQUE_BAND))
      s = wrap_torque(t * int'(balance_pkg::GAIN_MULTIPLIER));
    else if (t < 0)
      s = wrap_torque(t - int'(balance_pkg::MIN_DUTY));
    else
      s = wrap_torque(t + int'(balance_pkg::MIN_DUTY));
    rev  = (s < 0);
    smag = (s < 0) ? -s : s;   // -32768 becomes 32768, clamps below
    spd  = !pwr ? 0 : ((smag > int'(balance_pkg::SPD_MAX)) ? int'(balance_pkg::SPD_MAX) : smag);
  endtask

  task automatic compare_val(input string name, input logic [15:0] exp_v,
                             input logic [15:0] act_v);
    n_chk++;
    if (act_v !== exp_v) begin
      n_err++;
      $display("Mismatch %s expected 0x%h actual 0x%h at %0t", name, exp_v, act_v, $time);
    end
  endtask

  //////////////////////////////////////////////////
  // mirrored registers, same edge as the DUT
  //////////////////////////////////////////////////

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      m_integ <= 0;
      m_hist1 <= 0;
      m_hist2 <= 0;
    end else begin
      upd_err = pitch_to_err(ptch);   // inputs still hold the pre-edge values here
      upd_sum = m_integ + upd_err;
      if (rider_off)
        m_integ <= 0;
      else if (vld && upd_sum <= INTEG_MAX && upd_sum >= INTEG_MIN)
        m_integ <= upd_sum;           // out of range means freeze
      if (vld) begin
        m_hist1 <= upd_err;
        m_hist2 <= m_hist1;
      end
    end
  end

  //////////////////////////////////////////////////
  // expected outputs, compared mid cycle
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst_n) begin
      cur_err = pitch_to_err(ptch);
      pid = cur_err * int'(balance_pkg::P_COEFF)
          + (pwr_up ? wrap_torque(m_integ >>> I_SHIFT) : 0)
          + clamp(cur_err - m_hist2, int'(balance_pkg::DIFF_MIN), int'(balance_pkg::DIFF_MAX))
            * int'(balance_pkg::D_COEFF);
      pid   = wrap_torque(pid);
      steer = en_steer ? (int'(ld_cell_diff) >>> 3) : 0;   // floor of diff / 8
      shape_wheel(wrap_torque(pid - steer), pwr_up, l_spd, l_rev);
      shape_wheel(wrap_torque(pid + steer), pwr_up, r_spd, r_rev);
      compare_val("lft_spd", 16'(l_spd), 16'(lft_spd));
      compare_val("lft_rev", 16'(l_rev), 16'(lft_rev));
      compare_val("rght_spd", 16'(r_spd), 16'(rght_spd));
      compare_val("rght_rev", 16'(r_rev), 16'(rght_rev));
      compare_val("ovr_spd", 16'((l_spd > int'(balance_pkg::WARN_SPEED)) ||
                                 (r_spd > int'(balance_pkg::WARN_SPEED))), 16'(ovr_spd));
      if (!en_steer && (lft_spd !== rght_spd || lft_rev !== rght_rev)) begin
        n_err++;
        $display("left and right wheels differ with steering off at %0t", $time);
      end
    end
  end

endmodule

/* balance_cntrl.sv */
// balance controller top joining the pitch PID to the two-wheel motor drive
module balance_cntrl #(
  parameter bit fast_sim = 1'b0   // 16x integral term for quick simulation
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  vld,            // new inertial reading
  input  logic signed [balance_pkg::PTCH_W-1:0] ptch,           // measured pitch
  input  logic signed [balance_pkg::LD_W-1:0]   ld_cell_diff,   // lft_ld minus rght_ld
  input  logic                                  rider_off,      // no rider on the platform
  input  logic                                  en_steer,       // steering allowed
  input  logic                                  pwr_up,         // platform authorized to move
  output logic [balance_pkg::SPD_W-1:0]         lft_spd,        // left motor speed
  output logic                                  lft_rev,        // left motor reverse
  output logic [balance_pkg::SPD_W-1:0]         rght_spd,       // right motor speed
  output logic                                  rght_rev,       // right motor reverse
  output logic                                  ovr_spd         // over-speed warning
);

  balance_pkg::torque_t pid_cntrl;   // balance torque before steering

  //////////////////////////////////////////////////
  // PID from pitch
  //////////////////////////////////////////////////

  pid_ctrl #(
    .fast_sim (fast_sim)
  ) u_pid (
    .clk       (clk),
    .rst_n     (rst_n),
    .vld       (vld),
    .ptch      (ptch),
    .rider_off (rider_off),
    .pwr_up    (pwr_up),
    .pid_cntrl (pid_cntrl)
  );

  //////////////////////////////////////////////////
  // steering and wheel outputs
  //////////////////////////////////////////////////

  motor_drive u_drive (
    .pid_cntrl    (pid_cntrl),
    .ld_cell_diff (ld_cell_diff),
    .en_steer     (en_steer),
    .pwr_up       (pwr_up),
    .lft_spd      (lft_spd),
    .lft_rev      (lft_rev),
    .rght_spd     (rght_spd),
    .rght_rev     (rght_rev),
    .ovr_spd      (ovr_spd)
  );

endmodule

/* balance_pkg.sv */
// balance controller shared widths, gains, saturation limits and speed warning level
package balance_pkg;

  //////////////////////////////////////////////////
  // datapath widths
  //////////////////////////////////////////////////

  parameter int PTCH_W  = 16;  // raw pitch from inertial sensor
  parameter int ERR_W   = 10;  // saturated pitch error
  parameter int INTEG_W = 18;  // integrator accumulator
  parameter int DIFF_W  = 7;   // saturated derivative difference
  parameter int TORQ_W  = 16;  // torque and PID sum
  parameter int LD_W    = 12;  // left minus right load cell
  parameter int SPD_W   = 11;  // unsigned motor speed

  // signed payload types shared by the PID and the motor drive
  typedef logic signed [ERR_W-1:0]  err_t;
  typedef logic signed [TORQ_W-1:0] torque_t;

  //////////////////////////////////////////////////
  // loop gains and torque shaping
  //////////////////////////////////////////////////

  parameter torque_t P_COEFF = torque_t'(14);  // proportional gain
  parameter torque_t D_COEFF = torque_t'(20);  // derivative gain

  // below this magnitude the motor gets a plain gain instead of the duty offset
  parameter torque_t LOW_TORQUE_BAND = torque_t'(70);    // 5 * P_COEFF
  parameter torque_t GAIN_MULTIPLIER = torque_t'(15);    // 1 + MIN_DUTY / LOW_TORQUE_BAND
  parameter torque_t MIN_DUTY        = torque_t'(980);   // duty that just overcomes stiction

  //////////////////////////////////////////////////
  // saturation limits
  //////////////////////////////////////////////////

  parameter err_t ERR_MAX = err_t'(511);    // most positive 10-bit signed
  parameter err_t ERR_MIN = err_t'(-512);   // most negative 10-bit signed

  parameter logic signed [DIFF_W-1:0] DIFF_MAX = 7'sh3F;  // +63
  parameter logic signed [DIFF_W-1:0] DIFF_MIN = 7'sh40;  // -64

  parameter logic [SPD_W-1:0] SPD_MAX = 11'h7FF;  // unsigned speed ceiling

  // rider gets a piezo warning above this speed
  // a saturated speed of 0x7FF always trips it
  parameter logic [SPD_W-1:0] WARN_SPEED = 11'h600;  // 1536

endpackage

/* build.f */
balance_pkg.sv
pitch_integrator.sv
pitch_derivative.sv
pid_ctrl.sv
torque_shaper.sv
motor_drive.sv
balance_cntrl.sv
balance_checker.sv
tb_balance_cntrl.sv

/* motor_drive.sv */
// motor drive mixing steering into the PID torque and shaping each wheel's speed
module motor_drive (
  input  balance_pkg::torque_t                pid_cntrl,      // balance torque
  input  logic signed [balance_pkg::LD_W-1:0] ld_cell_diff,   // left minus right load
  input  logic                                en_steer,       // rider leaning to steer
  input  logic                                pwr_up,
  output logic [balance_pkg::SPD_W-1:0]       lft_spd,
  output logic                                lft_rev,
  output logic [balance_pkg::SPD_W-1:0]       rght_spd,
  output logic                                rght_rev,
  output logic                                ovr_spd         // either wheel too fast
);

  localparam int LW    = balance_pkg::LD_W;
  localparam int EXT_W = balance_pkg::TORQ_W - (LW - 3);   // sign bits after divide by 8

  balance_pkg::torque_t steer_adj;     // ld_cell_diff / 8 at torque width
  balance_pkg::torque_t lft_torque;
  balance_pkg::torque_t rght_torque;

  //////////////////////////////////////////////////
  // steering mix
  //////////////////////////////////////////////////

  // drop three LSBs and sign extend, same as arithmetic shift right by 3
  assign steer_adj = {{EXT_W{ld_cell_diff[LW-1]}}, ld_cell_diff[LW-1:3]};

  // heavier left load slows left wheel and speeds right one
  assign lft_torque  = en_steer ? (pid_cntrl - steer_adj) : pid_cntrl;
  assign rght_torque = en_steer ? (pid_cntrl + steer_adj) : pid_cntrl;

  //////////////////////////////////////////////////
  // per-wheel shaping
  //////////////////////////////////////////////////

  torque_shaper u_lft_shaper (
    .torque (lft_torque),
    .pwr_up (pwr_up),
    .spd    (lft_spd),
    .rev    (lft_rev)
  );

  torque_shaper u_rght_shaper (
    .torque (rght_torque),
    .pwr_up (pwr_up),
    .spd    (rght_spd),
    .rev    (rght_rev)
  );

  // piezo warning when either wheel passes the threshold
  assign ovr_spd = (lft_spd > balance_pkg::WARN_SPEED) ||
                   (rght_spd > balance_pkg::WARN_SPEED);

endmodule

/* pid_ctrl.sv */
// PID controller turning the pitch reading into a signed balance torque
module pid_ctrl #(
  parameter bit fast_sim = 1'b0   // speeds up the integral term for short sims
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  vld,         // new inertial reading ready
  input  logic signed [balance_pkg::PTCH_W-1:0] ptch,        // measured pitch
  input  logic                                  rider_off,   // clears the integrator
  input  logic                                  pwr_up,      // zeroes the I term when low
  output balance_pkg::torque_t                  pid_cntrl    // P + I + D
);

  localparam int IW      = balance_pkg::INTEG_W;
  localparam int TW      = balance_pkg::TORQ_W;
  localparam int I_SHIFT = fast_sim ? 2 : 6;   // fast sim uses 16x more integral

  balance_pkg::err_t    ptch_err;     // pitch clamped to 10 bits
  balance_pkg::torque_t p_term;
  balance_pkg::torque_t i_term;
  balance_pkg::torque_t d_term;
  logic signed [IW-1:0] integrator;   // accumulator from the integrator block
  logic signed [IW-1:0] integ_shr;    // accumulator scaled down

  //////////////////////////////////////////////////
  // error saturation and P term
  //////////////////////////////////////////////////

  always_comb begin
    if (ptch > balance_pkg::ERR_MAX) begin
      ptch_err = balance_pkg::ERR_MAX;                     // clip at +511
    end else if (ptch < balance_pkg::ERR_MIN) begin
      ptch_err = balance_pkg::ERR_MIN;                     // clip at -512
    end else begin
      ptch_err = ptch[balance_pkg::ERR_W-1:0];             // in range, keep low bits
    end
  end

  assign p_term = ptch_err * balance_pkg::P_COEFF;   // max |512 * 14| stays in 16 bits

  //////////////////////////////////////////////////
  // integral and derivative blocks
  //////////////////////////////////////////////////

  pitch_integrator u_integ (
    .clk        (clk),
    .rst_n      (rst_n),
    .vld        (vld),
    .rider_off  (rider_off),
    .ptch_err   (ptch_err),
    .integrator (integrator)
  );

  pitch_derivative u_deriv (
    .clk      (clk),
    .rst_n    (rst_n),
    .vld      (vld),
    .ptch_err (ptch_err),
    .d_term   (d_term)
  );

  // arithmetic shift keeps the sign, low 16 bits are the usable I term
  assign integ_shr = integrator >>> I_SHIFT;

  // no integral push while the platform is not authorized to move
  assign i_term = pwr_up ? integ_shr[TW-1:0] : '0;

  //////////////////////////////////////////////////
  // PID sum
  //////////////////////////////////////////////////

  assign pid_cntrl = p_term + i_term + d_term;   // wraps at 16 bits like the torque path

endmodule

/* pitch_derivative.sv */
// pitch derivative term from current error minus error two valid readings back
module pitch_derivative (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 vld,        // shifts the error history
  input  balance_pkg::err_t    ptch_err,   // current saturated error
  output balance_pkg::torque_t d_term      // D contribution at torque width
);

  localparam int EW = balance_pkg::ERR_W;
  localparam int DW = balance_pkg::DIFF_W;

  balance_pkg::err_t     err_hist1;   // error from the last valid reading
  balance_pkg::err_t     err_hist2;   // error from two valid readings ago
  logic signed [EW:0]    err_diff;    // one extra bit so the difference never wraps
  logic signed [DW-1:0]  diff_sat;    // difference clamped to 7 bits

  //////////////////////////////////////////////////
  // two-deep error history
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_hist1 <= '0;
      err_hist2 <= '0;
    end else if (vld) begin
      err_hist1 <= ptch_err;
      err_hist2 <= err_hist1;   // older sample slides back
    end
  end

  //////////////////////////////////////////////////
  // difference, clamp and scale
  //////////////////////////////////////////////////

  assign err_diff = {ptch_err[EW-1], ptch_err} - {err_hist2[EW-1], err_hist2};

  always_comb begin
    if (err_diff > balance_pkg::DIFF_MAX) begin
      diff_sat = balance_pkg::DIFF_MAX;            // too positive
    end else if (err_diff < balance_pkg::DIFF_MIN) begin
      diff_sat = balance_pkg::DIFF_MIN;            // too negative
    end else begin
      diff_sat = err_diff[DW-1:0];                 // already fits
    end
  end

  // 7-bit diff sign extends into the 16-bit product, |64 * 20| fits easily
  assign d_term = diff_sat * balance_pkg::D_COEFF;

endmodule

/* pitch_integrator.sv */
// pitch integrator accumulating saturated error, freezing on overflow, clearing on rider off
module pitch_integrator (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   vld,         // new inertial reading ready
  input  logic                                   rider_off,   // load cells see no rider
  input  balance_pkg::err_t                      ptch_err,    // saturated pitch error
  output logic signed [balance_pkg::INTEG_W-1:0] integrator   // running sum of error
);

  localparam int IW    = balance_pkg::INTEG_W;
  localparam int EXT_W = balance_pkg::INTEG_W - balance_pkg::ERR_W;  // sign bits to prepend

  logic signed [IW-1:0] err_ext;     // error at accumulator width
  logic signed [IW-1:0] nxt_integ;   // candidate sum
  logic                 same_sign;   // both addends share a sign
  logic                 ovfl;        // sum wrapped past the signed range

  //////////////////////////////////////////////////
  // next value and overflow detect
  //////////////////////////////////////////////////

  assign err_ext = {{EXT_W{ptch_err[balance_pkg::ERR_W-1]}}, ptch_err};

  assign nxt_integ = integrator + err_ext;

  // overflow only possible when adding like signs
  assign same_sign = (integrator[IW-1] == err_ext[IW-1]);
  assign ovfl      = same_sign && (nxt_integ[IW-1] != integrator[IW-1]);  // sign flipped

  //////////////////////////////////////////////////
  // accumulator register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      integrator <= '0;
    end else if (rider_off) begin
      integrator <= '0;          // rider stepped off, drop wound up error
    end else if (vld && !ovfl) begin
      integrator <= nxt_integ;   // accumulate only on a valid reading
    end
    // otherwise hold, which also freezes the sum at the rail on overflow
  end

endmodule

/* run_sim.sh */
#!/bin/sh
# build and run the balance controller testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary -Wno-fatal --top-module tb_balance_cntrl -f build.f \
  -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
  exit 0
fi
exit 1

/* tb_balance_cntrl.sv */
// balance controller testbench running random pitch, steering, rider and saturation phases
module tb_balance_cntrl;

  localparam int CLK_PER   = 40;
  localparam int RST_CYC   = 8;
  localparam int N_PWR_DN  = 200;
  localparam int N_PID     = 1000;
  localparam int N_STEER   = 1000;
  localparam int N_RIDER   = 600;
  localparam int N_SAT     = 800;   // per direction, well past the ~257 readings to the rail
  localparam int N_SETTLE  = 300;   // random pitch right after each wind up
  localparam int TOTAL_CYC = RST_CYC + N_PWR_DN + N_PID + N_STEER + N_RIDER
                           + 2 * (N_SAT + N_SETTLE) + 10;
  localparam int MARGIN    = 200;

  logic                                  clk;
  logic                                  rst_n;
  logic                                  vld;
  logic signed [balance_pkg::PTCH_W-1:0] ptch;
  logic signed [balance_pkg::LD_W-1:0]   ld_cell_diff;
  logic                                  rider_off;
  logic                                  en_steer;
  logic                                  pwr_up;
  logic [balance_pkg::SPD_W-1:0]         lft_spd;
  logic                                  lft_rev;
  logic [balance_pkg::SPD_W-1:0]         rght_spd;
  logic                                  rght_rev;
  logic                                  ovr_spd;
  int                                    err_cnt;
  int                                    chk_cnt;
  logic [31:0] lcg_state = 32'h61e5_65b0;
  int tests_run = 0;
  int tests_failed = 0;
  int err_mark = 0;    // checker errors when the current test started
  int ovr_seen = 0;    // cycles with the warning up in the saturation run

  balance_cntrl #(.fast_sim(1'b0)) uut (
    .clk(clk), .rst_n(rst_n), .vld(vld), .ptch(ptch), .ld_cell_diff(ld_cell_diff),
    .rider_off(rider_off), .en_steer(en_steer), .pwr_up(pwr_up),
    .lft_spd(lft_spd), .lft_rev(lft_rev), .rght_spd(rght_spd), .rght_rev(rght_rev),
    .ovr_spd(ovr_spd)
  );

  balance_checker #(.fast_sim(1'b0)) u_chk (
    .clk(clk), .rst_n(rst_n), .vld(vld), .ptch(ptch), .ld_cell_diff(ld_cell_diff),
    .rider_off(rider_off), .en_steer(en_steer), .pwr_up(pwr_up),
    .lft_spd(lft_spd), .lft_rev(lft_rev), .rght_spd(rght_spd), .rght_rev(rght_rev),
    .ovr_spd(ovr_spd), .err_cnt(err_cnt), .chk_cnt(chk_cnt)
  );

  //////////////////////////////////////////////////
  // random source and stimulus
  //////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic draw(output logic [31:0] r);
    lcg_state = lcg_next(lcg_state);
    r = lcg_state;
  endtask

  // mix of small, around the 10-bit clip and full range pitch
  function automatic logic [15:0] pick_pitch(input logic [31:0] r);
    case (r[31:30])
      2'b00:   return {{8{r[7]}}, r[7:0]};
      2'b01:   return {{5{r[10]}}, r[10:0]};
      default: return r[15:0];
    endcase
  endfunction

  task automatic run_random(input int n_cyc, input bit pwr, input bit steer, input bit rider);
    logic [31:0] r;
    repeat (n_cyc) begin
      @(posedge clk);
      draw(r);
      vld          <= r[0] | r[1];            // about three readings in four cycles
      ptch         <= pick_pitch(r);
      ld_cell_diff <= r[27:16];
      en_steer     <= pwr ? steer : r[2];     // powered down phase steers at random
      pwr_up       <= pwr;
      rider_off    <= rider && (r[14:12] == 3'b000);
    end
  endtask

  // steady lean far past the clip so the integrator runs into its rail
  task automatic run_saturate(input int n_cyc, input logic [15:0] base);
    logic [31:0] r;
    repeat (n_cyc) begin
      @(posedge clk);
      draw(r);
      vld          <= 1'b1;
      ptch         <= base + {8'h00, r[7:0]};
      ld_cell_diff <= r[27:16];
      en_steer     <= r[8];
      rider_off    <= 1'b0;
      @(negedge clk);
      if (ovr_spd === 1'b1) ovr_seen++;
    end
  endtask

  task automatic finish_test(input string name, input int extra);
    int n_new;
    @(negedge clk);
    #1;
    n_new = err_cnt - err_mark + extra;
    err_mark = err_cnt;
    tests_run++;
    if (n_new == 0) begin
      $display("test %-14s ok", name);
    end else begin
      tests_failed++;
      $display("test %-14s %0d errors", name, n_new);
    end
  endtask

  //////////////////////////////////////////////////
  // clock, watchdog, test sequence
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #(CLK_PER / 2) clk = ~clk;
  end

  initial begin
    #(CLK_PER * (TOTAL_CYC + MARGIN));
    $display("watchdog expired after %0d cycles, tests did not finish", TOTAL_CYC + MARGIN);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    rst_n        = 1'b0;
    vld          = 1'b0;
    ptch         = '0;
    ld_cell_diff = '0;
    rider_off    = 1'b0;
    en_steer     = 1'b0;
    pwr_up       = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    rst_n <= 1'b1;
    run_random(N_PWR_DN, 1'b0, 1'b0, 1'b0);
    finish_test("powered_down", 0);
    run_random(N_PID, 1'b1, 1'b0, 1'b0);
    finish_test("pid_no_steer", 0);
    run_random(N_STEER, 1'b1, 1'b1, 1'b0);
    finish_test("steering", 0);
    run_random(N_RIDER, 1'b1, 1'b1, 1'b1);
    finish_test("rider_off", 0);
    @(posedge clk);
    rider_off <= 1'b1;   // start the wind up from an empty integrator
    vld       <= 1'b0;
    run_saturate(N_SAT, 16'h2000);
    run_random(N_SETTLE, 1'b1, 1'b0, 1'b0);   // unsaturated cycles show the held I term
    run_saturate(N_SAT, 16'hdf00);
    run_random(N_SETTLE, 1'b1, 1'b0, 1'b0);
    if (ovr_seen == 0) $display("over-speed warning never rose during the saturation runs");
    finish_test("saturation", (ovr_seen == 0) ? 1 : 0);
    $display("summary: %0d tests, %0d failed, %0d checks, %0d mismatches",
             tests_run, tests_failed, chk_cnt, err_cnt);
    if (tests_failed == 0 && err_cnt == 0 && chk_cnt > 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

/* torque_shaper.sv */
// torque shaper mapping one wheel's torque to direction and saturated motor speed
module torque_shaper (
  input  balance_pkg::torque_t           torque,   // signed wheel torque
  input  logic                           pwr_up,   // speed forced to zero when low
  output logic [balance_pkg::SPD_W-1:0]  spd,      // unsigned motor speed
  output logic                           rev       // 1 runs the motor in reverse
);

  localparam int TW = balance_pkg::TORQ_W;
  localparam int SW = balance_pkg::SPD_W;

  logic [TW-1:0]        torq_mag;     // |torque|
  balance_pkg::torque_t torq_duty;    // torque pushed MIN_DUTY away from zero
  balance_pkg::torque_t torq_gain;    // torque times low-band gain
  balance_pkg::torque_t shaped;       // selected shaping result
  logic [TW-1:0]        shaped_mag;   // |shaped|
  logic                 in_low_band;

  //////////////////////////////////////////////////
  // shaping choice
  //////////////////////////////////////////////////

  assign torq_mag = torque[TW-1] ? -torque : torque;   // 0x8000 stays 0x8000, still large

  assign in_low_band = (torq_mag < balance_pkg::LOW_TORQUE_BAND);

  // offset keeps the sign of the request
  assign torq_duty = torque[TW-1] ? (torque - balance_pkg::MIN_DUTY)
                                  : (torque + balance_pkg::MIN_DUTY);

  // near zero a steep gain blends into the offset region without a jump
  assign torq_gain = torque * balance_pkg::GAIN_MULTIPLIER;   // truncated to 16 bits

  assign shaped = in_low_band ? torq_gain : torq_duty;

  //////////////////////////////////////////////////
  // direction and speed
  //////////////////////////////////////////////////

  assign rev = shaped[TW-1];

  assign shaped_mag = shaped[TW-1] ? -shaped : shaped;

  always_comb begin
    if (!pwr_up) begin
      spd = '0;                                  // not authorized, motors idle
    end else if (|shaped_mag[TW-1:SW]) begin
      spd = balance_pkg::SPD_MAX;                // too big for 11 bits, clamp
    end else begin
      spd = shaped_mag[SW-1:0];
    end
  end

endmodule
